// ==== hdl/usb_mem_config.svh ====
`ifndef USB_MEM_CONFIG_SVH
`define USB_MEM_CONFIG_SVH

// Memory address width, also the width of the frame address and length fields
`define USB_MEM_ADDR_W 8

// Bytes of shared on-chip memory
`define USB_MEM_DEPTH 256

// Input FIFO depth per channel, equal to the host's starting credits
`define USB_MEM_IN_CREDITS 4

// Response bytes the host can take straight after reset
`define USB_MEM_OUT_CREDITS 4

`endif

// ==== hdl/usb_mem_pkg.sv ====
package usb_mem_pkg;

`include "usb_mem_config.svh"

  // Command opcodes, every other value is rejected
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02
  } opcode_e;

  // Endpoint engine states
  typedef enum logic [2:0] {
    ST_OPCODE,
    ST_ADDR,
    ST_LEN,
    ST_WDATA,
    ST_RDATA,
    ST_ACK,
    ST_DRAIN,
    ST_ERROR
  } engine_state_e;

  // One byte of a frame, last marks the final byte
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  typedef struct packed {
    logic                       we;     // High for a write
    logic [`USB_MEM_ADDR_W-1:0] addr;
    logic [7:0]                 wdata;
  } mem_req_t;

  // Response codes
  localparam logic [7:0] ACK_OK     = 8'hA5;
  localparam logic [7:0] ERR_OPCODE = 8'hEE;

endpackage

// ==== hdl/cmd_fifo.sv ====
`timescale 1ns/1ps
`include "usb_mem_config.svh"

module cmd_fifo (
  input  logic                    clock_i,
  input  logic                    reset_i,
  input  logic                    push_i,
  input  usb_mem_pkg::byte_beat_t push_beat_i,
  input  logic                    pop_i,
  output logic                    empty_o,
  output usb_mem_pkg::byte_beat_t head_o,
  output logic                    credit_o
);
  import usb_mem_pkg::*;

  localparam int DEPTH = `USB_MEM_IN_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  byte_beat_t     fifo_mem [DEPTH];
  logic [PTR_W:0] wr_ptr_q;  // Extra bit tells full from empty
  logic [PTR_W:0] rd_ptr_q;
  logic           full;
  logic           do_push;
  logic           do_pop;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full    = (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]) &&
                   (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]);

  assign do_push  = push_i && !full;   // Host should never push when full
  assign do_pop   = pop_i && !empty_o;
  assign credit_o = do_pop;            // One credit back per byte consumed
  assign head_o   = fifo_mem[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (do_push) begin
      fifo_mem[wr_ptr_q[PTR_W-1:0]] <= push_beat_i;
    end
  end

endmodule

// ==== hdl/ep_engine.sv ====
`timescale 1ns/1ps
`include "usb_mem_config.svh"

module ep_engine (
  input  logic                        clock_i,
  input  logic                        reset_i,
  input  logic                        fifo_empty_i,
  input  usb_mem_pkg::byte_beat_t     fifo_head_i,
  output logic                        fifo_pop_o,
  output logic                        req_valid_o,
  output usb_mem_pkg::mem_req_t       req_o,
  input  logic                        gnt_i,
  input  logic                        rd_valid_i,
  input  logic [7:0]                  rd_data_i,
  output logic                        out_valid_o,
  output usb_mem_pkg::byte_beat_t     out_beat_o,
  input  logic                        out_credit_i
);
  import usb_mem_pkg::*;

  localparam int LEN_W  = `USB_MEM_ADDR_W;
  localparam int CRED_W = $clog2(`USB_MEM_OUT_CREDITS + 1) + 1;

  engine_state_e     state_q;
  opcode_e           op_q;
  logic [LEN_W-1:0]  addr_q;
  logic [LEN_W-1:0]  issue_left_q;  // Requests still to be granted
  logic [LEN_W-1:0]  recv_left_q;   // Read bytes still to come back
  logic [CRED_W-1:0] credits_q;
  logic              drain_q;
  logic              send_ctl;
  logic              credit_take;

  // ACK or error byte leaves this cycle
  assign send_ctl    = ((state_q == ST_ACK) || (state_q == ST_ERROR)) && (credits_q != '0);
  assign credit_take = send_ctl || ((state_q == ST_RDATA) && gnt_i);

  always_comb begin
    fifo_pop_o   = 1'b0;
    req_valid_o  = 1'b0;
    req_o.we     = 1'b0;
    req_o.addr   = addr_q;
    req_o.wdata  = fifo_head_i.data;
    case (state_q)
      ST_OPCODE, ST_ADDR, ST_LEN, ST_DRAIN: begin
        fifo_pop_o = !fifo_empty_i;
      end
      ST_WDATA: begin
        req_valid_o = !fifo_empty_i;
        req_o.we    = 1'b1;
        fifo_pop_o  = gnt_i;  // Data byte leaves the FIFO once written
      end
      ST_RDATA: begin
        // Each read needs an output credit reserved up front
        req_valid_o = (issue_left_q != '0) && (credits_q != '0);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      credits_q <= CRED_W'(`USB_MEM_OUT_CREDITS);
    end else if (out_credit_i && !credit_take) begin
      credits_q <= credits_q + 1'b1;
    end else if (!out_credit_i && credit_take) begin
      credits_q <= credits_q - 1'b1;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q      <= ST_OPCODE;
      out_valid_o  <= 1'b0;
      issue_left_q <= '0;
      recv_left_q  <= '0;
      drain_q      <= 1'b0;
    end else begin
      out_valid_o <= 1'b0;
      case (state_q)
        ST_OPCODE: begin
          if (!fifo_empty_i) begin
            case (fifo_head_i.data)
              OP_WRITE, OP_READ: begin
                op_q    <= opcode_e'(fifo_head_i.data);
                state_q <= ST_ADDR;
              end
              default: begin
                drain_q <= !fifo_head_i.last;  // Skip the rest of the frame
                state_q <= ST_ERROR;
              end
            endcase
          end
        end
        ST_ADDR: begin
          if (!fifo_empty_i) begin
            addr_q  <= fifo_head_i.data;
            state_q <= ST_LEN;
          end
        end
        ST_LEN: begin
          if (!fifo_empty_i) begin
            issue_left_q <= fifo_head_i.data;
            recv_left_q  <= fifo_head_i.data;
            if (fifo_head_i.data == '0) begin
              state_q <= ST_ACK;  // Zero length answers with a plain ACK
            end else if (op_q == OP_READ) begin
              state_q <= ST_RDATA;
            end else begin
              state_q <= ST_WDATA;
            end
          end
        end
        ST_WDATA: begin
          if (gnt_i) begin
            addr_q       <= addr_q + 1'b1;
            issue_left_q <= issue_left_q - 1'b1;
            if (issue_left_q == LEN_W'(1)) begin
              state_q <= ST_ACK;
            end
          end
        end
        ST_RDATA: begin
          if (gnt_i) begin
            addr_q       <= addr_q + 1'b1;
            issue_left_q <= issue_left_q - 1'b1;
          end
          if (rd_valid_i) begin
            out_valid_o     <= 1'b1;
            out_beat_o.data <= rd_data_i;
            out_beat_o.last <= (recv_left_q == LEN_W'(1));
            recv_left_q     <= recv_left_q - 1'b1;
            if (recv_left_q == LEN_W'(1)) begin
              state_q <= ST_OPCODE;
            end
          end
        end
        ST_ACK: begin
          if (send_ctl) begin
            out_valid_o     <= 1'b1;
            out_beat_o.data <= ACK_OK;
            out_beat_o.last <= 1'b1;
            state_q         <= ST_OPCODE;
          end
        end
        ST_ERROR: begin
          if (send_ctl) begin
            out_valid_o     <= 1'b1;
            out_beat_o.data <= ERR_OPCODE;
            out_beat_o.last <= 1'b1;
            state_q         <= drain_q ? ST_DRAIN : ST_OPCODE;
          end
        end
        ST_DRAIN: begin
          if (!fifo_empty_i && fifo_head_i.last) begin
            state_q <= ST_OPCODE;
          end
        end
        default: state_q <= ST_OPCODE;
      endcase
    end
  end

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  logic [1:0]            req_valid_i,
  input  usb_mem_pkg::mem_req_t req0_i,
  input  usb_mem_pkg::mem_req_t req1_i,
  output logic [1:0]            gnt_o,
  output logic                  mem_req_valid_o,
  output usb_mem_pkg::mem_req_t mem_req_o,
  input  logic [7:0]            rd_data_i,
  output logic [1:0]            rd_valid_o,
  output logic [7:0]            rd_data_o
);

  logic       prio_q;     // Port that wins a tie
  logic [1:0] rd_pend_q;  // Port owning the read returning this cycle

  always_comb begin
    gnt_o = 2'b00;
    if (prio_q == 1'b0) begin
      gnt_o[0] = req_valid_i[0];
      gnt_o[1] = req_valid_i[1] && !req_valid_i[0];
    end else begin
      gnt_o[1] = req_valid_i[1];
      gnt_o[0] = req_valid_i[0] && !req_valid_i[1];
    end
  end

  assign mem_req_valid_o = |gnt_o;
  assign mem_req_o       = gnt_o[1] ? req1_i : req0_i;

  // SRAM data is simply steered to whoever asked for it
  assign rd_valid_o = rd_pend_q;
  assign rd_data_o  = rd_data_i;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      prio_q    <= 1'b0;
      rd_pend_q <= 2'b00;
    end else begin
      if (gnt_o[0]) begin
        prio_q <= 1'b1;  // Last winner drops to low priority
      end else if (gnt_o[1]) begin
        prio_q <= 1'b0;
      end
      rd_pend_q <= gnt_o & {!req1_i.we, !req0_i.we};
    end
  end

endmodule

// ==== hdl/byte_sram.sv ====
`timescale 1ns/1ps
`include "usb_mem_config.svh"

module byte_sram (
  input  logic                  clock_i,
  input  logic                  req_valid_i,
  input  usb_mem_pkg::mem_req_t req_i,
  output logic [7:0]            rd_data_o
);

  logic [7:0] mem_q [`USB_MEM_DEPTH];

  always_ff @(posedge clock_i) begin
    if (req_valid_i) begin
      if (req_i.we) begin
        mem_q[req_i.addr] <= req_i.wdata;
      end
      rd_data_o <= mem_q[req_i.addr];  // Registered read, ready next cycle
    end
  end

endmodule

// ==== hdl/usb_mem_top.sv ====
`timescale 1ns/1ps

module usb_mem_top (
  input  logic                    clock_i,
  input  logic                    reset_i,
  // Endpoint 1
  input  logic                    ep1_in_valid_i,
  input  usb_mem_pkg::byte_beat_t ep1_in_beat_i,
  output logic                    ep1_in_credit_o,
  output logic                    ep1_out_valid_o,
  output usb_mem_pkg::byte_beat_t ep1_out_beat_o,
  input  logic                    ep1_out_credit_i,
  // Endpoint 2
  input  logic                    ep2_in_valid_i,
  input  usb_mem_pkg::byte_beat_t ep2_in_beat_i,
  output logic                    ep2_in_credit_o,
  output logic                    ep2_out_valid_o,
  output usb_mem_pkg::byte_beat_t ep2_out_beat_o,
  input  logic                    ep2_out_credit_i
);
  import usb_mem_pkg::*;

  logic       fifo_empty1, fifo_empty2, fifo_pop1, fifo_pop2;
  byte_beat_t fifo_head1, fifo_head2;
  logic [1:0] req_valid, gnt, rd_valid;
  mem_req_t   req1, req2;
  logic       mem_req_valid;
  mem_req_t   mem_req;
  logic [7:0] mem_rd_data, rd_data;

  cmd_fifo u_fifo1 (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .push_i     (ep1_in_valid_i),
    .push_beat_i(ep1_in_beat_i),
    .pop_i      (fifo_pop1),
    .empty_o    (fifo_empty1),
    .head_o     (fifo_head1),
    .credit_o   (ep1_in_credit_o)
  );

  cmd_fifo u_fifo2 (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .push_i     (ep2_in_valid_i),
    .push_beat_i(ep2_in_beat_i),
    .pop_i      (fifo_pop2),
    .empty_o    (fifo_empty2),
    .head_o     (fifo_head2),
    .credit_o   (ep2_in_credit_o)
  );

  ep_engine u_eng1 (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .fifo_empty_i(fifo_empty1),
    .fifo_head_i (fifo_head1),
    .fifo_pop_o  (fifo_pop1),
    .req_valid_o (req_valid[0]),
    .req_o       (req1),
    .gnt_i       (gnt[0]),
    .rd_valid_i  (rd_valid[0]),
    .rd_data_i   (rd_data),
    .out_valid_o (ep1_out_valid_o),
    .out_beat_o  (ep1_out_beat_o),
    .out_credit_i(ep1_out_credit_i)
  );

  ep_engine u_eng2 (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .fifo_empty_i(fifo_empty2),
    .fifo_head_i (fifo_head2),
    .fifo_pop_o  (fifo_pop2),
    .req_valid_o (req_valid[1]),
    .req_o       (req2),
    .gnt_i       (gnt[1]),
    .rd_valid_i  (rd_valid[1]),
    .rd_data_i   (rd_data),
    .out_valid_o (ep2_out_valid_o),
    .out_beat_o  (ep2_out_beat_o),
    .out_credit_i(ep2_out_credit_i)
  );

  mem_arbiter u_arb (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .req_valid_i    (req_valid),
    .req0_i         (req1),
    .req1_i         (req2),
    .gnt_o          (gnt),
    .mem_req_valid_o(mem_req_valid),
    .mem_req_o      (mem_req),
    .rd_data_i      (mem_rd_data),
    .rd_valid_o     (rd_valid),
    .rd_data_o      (rd_data)
  );

  byte_sram u_mem (
    .clock_i    (clock_i),
    .req_valid_i(mem_req_valid),
    .req_i      (mem_req),
    .rd_data_o  (mem_rd_data)
  );

endmodule

// ==== verification/usb_mem_chk.sv ====
`timescale 1ns/1ps
`include "usb_mem_config.svh"

module usb_mem_chk (
  input logic       clock_i,
  input logic       reset_i,
  input logic [1:0] gnt_i,
  input logic [1:0] req_valid_i,
  input logic       ep1_in_valid_i,
  input logic       ep1_in_credit_i,
  input logic       ep1_pop_i,
  input logic       ep1_out_valid_i,
  input logic       ep1_out_credit_i,
  input logic       ep2_in_valid_i,
  input logic       ep2_in_credit_i,
  input logic       ep2_pop_i,
  input logic       ep2_out_valid_i,
  input logic       ep2_out_credit_i
);

  int   cred1;               // Host side output credits
  int   cred2;
  int   fill1;               // Input FIFO occupancy, real pushes minus real pops
  int   fill2;
  logic rst_seen_q = 1'b0;   // Reset already seen at a clock edge

  always @(posedge clock_i) begin
    rst_seen_q <= reset_i;
    if (reset_i) begin
      cred1 <= `USB_MEM_OUT_CREDITS;
      cred2 <= `USB_MEM_OUT_CREDITS;
      fill1 <= 0;
      fill2 <= 0;
    end else begin
      cred1 <= cred1 + int'(ep1_out_credit_i) - int'(ep1_out_valid_i);
      cred2 <= cred2 + int'(ep2_out_credit_i) - int'(ep2_out_valid_i);
      fill1 <= fill1 + int'(ep1_in_valid_i) - int'(ep1_pop_i);
      fill2 <= fill2 + int'(ep2_in_valid_i) - int'(ep2_pop_i);
    end
  end

  a_gnt_onehot: assert property (@(posedge clock_i) disable iff (reset_i) $onehot0(gnt_i))
    else $error("Arbiter granted both ports in one cycle");

  a_out_credit: assert property (@(posedge clock_i) disable iff (reset_i)
    (ep1_out_valid_i |-> cred1 > 0) and (ep2_out_valid_i |-> cred2 > 0))
    else $error("Response byte sent with no output credit left");

  a_fifo_room: assert property (@(posedge clock_i) disable iff (reset_i)
    (ep1_in_valid_i |-> fill1 < `USB_MEM_IN_CREDITS) and
    (ep2_in_valid_i |-> fill2 < `USB_MEM_IN_CREDITS))
    else $error("Byte pushed into a full input FIFO");

  a_reset_quiet: assert property (@(posedge clock_i) (reset_i && rst_seen_q) |->
    (gnt_i == 2'b00) && (req_valid_i == 2'b00) && !ep1_out_valid_i && !ep2_out_valid_i &&
    !ep1_in_credit_i && !ep2_in_credit_i)
    else $error("Control output active during reset");

endmodule

bind usb_mem_top usb_mem_chk u_chk (
  .clock_i         (clock_i),
  .reset_i         (reset_i),
  .gnt_i           (gnt),
  .req_valid_i     (req_valid),
  .ep1_in_valid_i  (ep1_in_valid_i),
  .ep1_in_credit_i (ep1_in_credit_o),
  .ep1_pop_i       (fifo_pop1 && !fifo_empty1),
  .ep1_out_valid_i (ep1_out_valid_o),
  .ep1_out_credit_i(ep1_out_credit_i),
  .ep2_in_valid_i  (ep2_in_valid_i),
  .ep2_in_credit_i (ep2_in_credit_o),
  .ep2_pop_i       (fifo_pop2 && !fifo_empty2),
  .ep2_out_valid_i (ep2_out_valid_o),
  .ep2_out_credit_i(ep2_out_credit_i)
);

// ==== verification/usb_mem_monitor.sv ====
`timescale 1ns/1ps
`include "usb_mem_config.svh"

module usb_mem_monitor (
  input logic                    clock_i,
  input logic                    reset_i,
  input logic                    ep1_out_valid_i,
  input usb_mem_pkg::byte_beat_t ep1_out_beat_i,
  input logic                    ep1_out_credit_i,
  input logic                    ep2_out_valid_i,
  input usb_mem_pkg::byte_beat_t ep2_out_beat_i,
  input logic                    ep2_out_credit_i
);
  import usb_mem_pkg::*;

  byte_beat_t exp1_q [$];  // Expected EP1 response bytes in order
  byte_beat_t exp2_q [$];
  int         host_cred [2];
  int         mismatch_cnt = 0;
  int         unexpected_cnt = 0;
  int         credit_cnt = 0;
  int         leftover_cnt = 0;

  task automatic expect_beat(input int ch, input byte_beat_t beat);
    if (ch == 0) exp1_q.push_back(beat);
    else exp2_q.push_back(beat);
  endtask

  function automatic int pending(input int ch);
    return (ch == 0) ? exp1_q.size() : exp2_q.size();
  endfunction

  function automatic int error_total();
    return mismatch_cnt + unexpected_cnt + credit_cnt + leftover_cnt;
  endfunction

  task automatic check_beat(input int ch, input byte_beat_t got);
    byte_beat_t want;
    if (host_cred[ch] <= 0) begin
      credit_cnt++;
      $display("At %0t EP%0d sent a response byte without an output credit", $time, ch + 1);
    end
    if (pending(ch) == 0) begin
      unexpected_cnt++;
      $display("At %0t EP%0d sent byte %02h when no response was expected",
               $time, ch + 1, got.data);
    end else begin
      want = (ch == 0) ? exp1_q.pop_front() : exp2_q.pop_front();
      if (got.data !== want.data) begin
        mismatch_cnt++;
        $display("MISMATCH time=%0t signal=ep%0d_out_beat_o.data got=%02h expected=%02h",
                 $time, ch + 1, got.data, want.data);
      end
      if (got.last !== want.last) begin
        mismatch_cnt++;
        $display("MISMATCH time=%0t signal=ep%0d_out_beat_o.last got=%b expected=%b",
                 $time, ch + 1, got.last, want.last);
      end
    end
  endtask

  task automatic report_leftover();
    for (int c = 0; c < 2; c++) begin
      if (pending(c) != 0) begin
        leftover_cnt += pending(c);
        $display("EP%0d still owes %0d response bytes at the end", c + 1, pending(c));
      end
    end
  endtask

  always @(posedge clock_i) begin
    if (reset_i) begin
      host_cred[0] = `USB_MEM_OUT_CREDITS;
      host_cred[1] = `USB_MEM_OUT_CREDITS;
    end else begin
      if (ep1_out_valid_i) check_beat(0, ep1_out_beat_i);
      if (ep2_out_valid_i) check_beat(1, ep2_out_beat_i);
      host_cred[0] = host_cred[0] + int'(ep1_out_credit_i) - int'(ep1_out_valid_i);
      host_cred[1] = host_cred[1] + int'(ep2_out_credit_i) - int'(ep2_out_valid_i);
    end
  end

endmodule

// ==== verification/tb_usb_mem.sv ====
`timescale 1ns/1ps
`include "usb_mem_config.svh"

module tb_usb_mem;
  import usb_mem_pkg::*;

  localparam int PAT_WORDS = 512;
  localparam int MAX_RECS  = 64;

  logic        clock;
  logic        reset;
  logic        in_valid [2];
  byte_beat_t  in_beat [2];
  logic        in_credit [2];
  logic        out_valid [2];
  byte_beat_t  out_beat [2];
  logic        out_credit [2];
  logic [7:0]  pat [PAT_WORDS];
  int          rec_ch [MAX_RECS];
  int          rec_phase [MAX_RECS];
  int          rec_pos [MAX_RECS];   // Index of the frame length word
  int          num_recs;
  int          num_phases;
  int          total_bytes;
  int          in_sent [2];
  int          in_ret [2];
  int          owed [2];              // Response bytes taken but not yet credited back
  int          tb_errors;
  logic [31:0] lfsr_state;
  logic [7:0]  rnd_q;

  usb_mem_top u_dut (
    .clock_i         (clock),
    .reset_i         (reset),
    .ep1_in_valid_i  (in_valid[0]),
    .ep1_in_beat_i   (in_beat[0]),
    .ep1_in_credit_o (in_credit[0]),
    .ep1_out_valid_o (out_valid[0]),
    .ep1_out_beat_o  (out_beat[0]),
    .ep1_out_credit_i(out_credit[0]),
    .ep2_in_valid_i  (in_valid[1]),
    .ep2_in_beat_i   (in_beat[1]),
    .ep2_in_credit_o (in_credit[1]),
    .ep2_out_valid_o (out_valid[1]),
    .ep2_out_beat_o  (out_beat[1]),
    .ep2_out_credit_i(out_credit[1])
  );

  usb_mem_monitor u_mon (
    .clock_i         (clock),
    .reset_i         (reset),
    .ep1_out_valid_i (out_valid[0]),
    .ep1_out_beat_i  (out_beat[0]),
    .ep1_out_credit_i(out_credit[0]),
    .ep2_out_valid_i (out_valid[1]),
    .ep2_out_beat_i  (out_beat[1]),
    .ep2_out_credit_i(out_credit[1])
  );

  always #10 clock = ~clock;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Bits 1:0 let a channel send, bits 7:2 decide credit returns
  always @(posedge clock) begin : draw_bits
    logic [7:0] bits;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits[i]    = lfsr_state[0];
    end
    rnd_q <= bits;
  end

  // Host bookkeeping for both credit directions
  always @(posedge clock) begin : host_credits
    logic give;
    for (int c = 0; c < 2; c++) begin
      give = (owed[c] > 0) && (&rnd_q[2 + 3 * c +: 3]);  // Rare, so the engine stalls
      if (reset) begin
        owed[c]       <= 0;
        in_ret[c]     <= 0;
        out_credit[c] <= 1'b0;
      end else begin
        owed[c]       <= owed[c] + int'(out_valid[c]) - int'(give);
        in_ret[c]     <= in_ret[c] + int'(in_credit[c]);
        out_credit[c] <= give;
      end
    end
  end

  task automatic load_patterns();
    int pos;
    int nf;
    int nr;
    int phase;
    $readmemh("verification/usb_mem_patterns.txt", pat);
    pos         = 0;
    phase       = 0;
    num_recs    = 0;
    total_bytes = 0;
    while (pos < PAT_WORDS && num_recs < MAX_RECS &&
           (pat[pos] == 8'h01 || pat[pos] == 8'h02 || pat[pos] == 8'h03)) begin
      if (pat[pos] == 8'h03) begin
        phase++;  // Barrier between phases
        pos++;
      end else begin
        nf                  = pat[pos + 1];
        nr                  = pat[pos + 2 + nf];
        rec_ch[num_recs]    = pat[pos];
        rec_phase[num_recs] = phase;
        rec_pos[num_recs]   = pos + 1;
        num_recs++;
        total_bytes += nf + nr;
        pos += 3 + nf + nr;
      end
    end
    num_phases = phase + 1;
  endtask

  task automatic send_phase(input int ch, input int phase);
    int pos;
    int nf;
    int nr;
    int k;
    for (int r = 0; r < num_recs; r++) begin
      if (rec_ch[r] == ch + 1 && rec_phase[r] == phase) begin
        pos = rec_pos[r];
        nf  = pat[pos];
        nr  = pat[pos + nf + 1];
        for (int j = 0; j < nr; j++) begin
          u_mon.expect_beat(ch, '{data: pat[pos + nf + 2 + j], last: (j == nr - 1)});
        end
        k = 0;
        while (k < nf) begin
          @(posedge clock);
          if ((`USB_MEM_IN_CREDITS + in_ret[ch] - in_sent[ch] > 0) && rnd_q[ch]) begin
            in_valid[ch] <= 1'b1;
            in_beat[ch]  <= '{data: pat[pos + 1 + k], last: (k == nf - 1)};
            in_sent[ch]++;
            k++;
          end else begin
            in_valid[ch] <= 1'b0;  // Idle gap or out of credits
          end
        end
      end
    end
    @(posedge clock);
    in_valid[ch] <= 1'b0;
  endtask

  task automatic run_watchdog();
    repeat (total_bytes * 40 + 1000) @(posedge clock);
    $display("Run timed out after %0d cycles", total_bytes * 40 + 1000);
    u_mon.report_leftover();
    $display("ERRORS FOUND");
    $finish;
  endtask

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    tb_errors  = 0;
    lfsr_state = 32'h3cb6_5979;
    for (int c = 0; c < 2; c++) begin
      in_valid[c]   = 1'b0;
      in_beat[c]    = '0;
      out_credit[c] = 1'b0;
      in_sent[c]    = 0;
    end
    load_patterns();
    if (num_recs == 0) begin
      tb_errors++;
      $display("No frames could be read from the pattern file");
    end
    fork
      run_watchdog();
    join_none
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    for (int p = 0; p < num_phases; p++) begin
      fork
        send_phase(0, p);
        send_phase(1, p);
      join
      while (u_mon.pending(0) != 0 || u_mon.pending(1) != 0) @(posedge clock);
    end
    repeat (50) @(posedge clock);  // Catch stray bytes after the last response
    u_mon.report_leftover();
    $display("Error counts: mismatch %0d, unexpected %0d, credit %0d, leftover %0d, other %0d",
             u_mon.mismatch_cnt, u_mon.unexpected_cnt, u_mon.credit_cnt,
             u_mon.leftover_cnt, tb_errors);
    if (u_mon.error_total() + tb_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/usb_mem_pkg.sv
hdl/cmd_fifo.sv
hdl/ep_engine.sv
hdl/mem_arbiter.sv
hdl/byte_sram.sv
hdl/usb_mem_top.sv
verification/usb_mem_chk.sv
verification/usb_mem_monitor.sv
verification/tb_usb_mem.sv

// ==== verification/usb_mem_patterns.txt ====
// Columns: type, frame byte count, frame bytes, response byte count, response bytes
// Type 01 is EP1, 02 is EP2, 03 waits for all responses, 00 ends the list
// Write then read back on EP1, zero-length read on EP2
01 07 01 10 04 11 22 33 44 01 A5
01 03 02 10 04 04 11 22 33 44
02 03 02 30 00 01 A5
03
// Both channels on disjoint regions at once
01 08 01 40 05 a0 a1 a2 a3 a4 01 A5
02 07 01 80 04 b0 b1 b2 b3 01 A5
01 03 02 40 05 05 a0 a1 a2 a3 a4
02 03 02 80 04 04 b0 b1 b2 b3
03
// EP1 writes a region that EP2 reads once the ACK is back
01 09 01 c0 06 c1 c2 c3 c4 c5 c6 01 A5
03
02 03 02 c0 06 06 c1 c2 c3 c4 c5 c6
// Bad opcodes, with and without last on the opcode byte
02 05 7f 11 22 33 44 01 EE
02 03 02 10 02 02 11 22
01 01 55 01 EE
// Read longer than the output credits
01 0f 01 20 0c d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db 01 A5
01 03 02 20 0c 0c d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db
00
